// ==== common/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Bus, register and memory word width
`define DATA_WIDTH 32

// Word address into main memory
`define ADDR_WIDTH 9
`define MEM_DEPTH 512

// General purpose registers R0 to R15
`define REG_COUNT 16

`endif

// ==== common/isaPkg.sv ====
`default_nettype none

`include "cpu_params.svh"

package isaPkg;

	// Only the load group is implemented, anything else halts
	typedef enum logic [4:0] {
		OP_LD   = 5'b00000,
		OP_LDI  = 5'b00001,
		OP_HALT = 5'b11011
	} opcodeT;

	typedef logic [$clog2(`REG_COUNT)-1:0] regIdxT;

	// Signed displacement, sign-extended onto the bus
	typedef logic [18:0] constT;

	// Instruction word layout, MSB first
	typedef struct packed {
		opcodeT opcode;
		regIdxT ra;
		regIdxT rb;
		constT  c;
	} instrT;

endpackage

`default_nettype wire

// ==== common/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

	// Control steps of the sequencer
	typedef enum logic [3:0] {
		S_IDLE,
		S_T0,
		S_T1,
		S_T2,
		S_T3,
		S_T4,
		S_T5,
		S_T6,
		S_T7,
		S_HALT
	} stepT;

	// Bus driver select, BUS_NONE leaves the bus at zero
	typedef enum logic [2:0] {
		BUS_NONE,
		BUS_PC,
		BUS_MDR,
		BUS_ZLO,
		BUS_REG,
		BUS_CONST
	} busSourceT;

endpackage

`default_nettype wire

// ==== common/ctrlIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf
	import ctrlPkg::*, isaPkg::*;
();

	busSourceT busSel;

	// Register load strobes
	logic marIn;
	logic mdrIn;
	logic irIn;
	logic yIn;
	logic zIn;
	logic pcInc;

	// MDR takes memory data instead of the bus
	logic memRead;

	// Register file select and encode
	logic gRa;
	logic gRb;
	logic baOut;
	logic rIn;

	opcodeT opcode;

	modport sequencer (
		output busSel, marIn, mdrIn, irIn, yIn, zIn, pcInc, memRead,
		output gRa, gRb, baOut, rIn,
		input  opcode
	);

	modport datapath (
		input  busSel, marIn, mdrIn, irIn, yIn, zIn, pcInc, memRead,
		input  gRa, gRb, baOut, rIn,
		output opcode
	);

endinterface

`default_nettype wire

// ==== src/controlSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlSequencer
	import ctrlPkg::*, isaPkg::*;
(
	input  logic     clk,
	input  logic     arstN,
	input  logic     run,
	ctrlIf.sequencer ctrl,
	output logic     instrDone,
	output logic     halted
);

	stepT step;
	stepT stepNext;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			step <= S_IDLE;
		end else begin
			step <= stepNext;
		end
	end

	always_comb begin
		stepNext = step;
		case (step)
			S_IDLE: stepNext = run ? S_T0 : S_IDLE;
			S_T0:   stepNext = S_T1;
			S_T1:   stepNext = S_T2;
			// Opcode is seen while IR loads, so halt stops here
			S_T2: begin
				if (ctrl.opcode == OP_LD || ctrl.opcode == OP_LDI) begin
					stepNext = S_T3;
				end else begin
					stepNext = S_HALT;
				end
			end
			S_T3: stepNext = S_T4;
			S_T4: stepNext = S_T5;
			S_T5: begin
				if (ctrl.opcode == OP_LDI) begin
					stepNext = run ? S_T0 : S_IDLE;
				end else begin
					stepNext = S_T6;
				end
			end
			S_T6:   stepNext = S_T7;
			S_T7:   stepNext = run ? S_T0 : S_IDLE;
			S_HALT: stepNext = S_HALT;
			default: stepNext = S_IDLE;
		endcase
	end

	// One set of strobes per step
	always_comb begin
		ctrl.busSel  = BUS_NONE;
		ctrl.marIn   = 1'b0;
		ctrl.mdrIn   = 1'b0;
		ctrl.memRead = 1'b0;
		ctrl.pcInc   = 1'b0;
		ctrl.irIn    = 1'b0;
		ctrl.yIn     = 1'b0;
		ctrl.zIn     = 1'b0;
		ctrl.gRa     = 1'b0;
		ctrl.gRb     = 1'b0;
		ctrl.baOut   = 1'b0;
		ctrl.rIn     = 1'b0;
		instrDone    = 1'b0;
		case (step)
			S_T0: begin
				ctrl.busSel = BUS_PC;
				ctrl.marIn  = 1'b1;
			end
			S_T1: begin
				ctrl.pcInc   = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.mdrIn   = 1'b1;
			end
			S_T2: begin
				ctrl.busSel = BUS_MDR;
				ctrl.irIn   = 1'b1;
			end
			// Base address into Y, R0 reads as zero here
			S_T3: begin
				ctrl.gRb    = 1'b1;
				ctrl.baOut  = 1'b1;
				ctrl.busSel = BUS_REG;
				ctrl.yIn    = 1'b1;
			end
			S_T4: begin
				ctrl.busSel = BUS_CONST;
				ctrl.zIn    = 1'b1;
			end
			S_T5: begin
				ctrl.busSel = BUS_ZLO;
				if (ctrl.opcode == OP_LDI) begin
					ctrl.gRa  = 1'b1;
					ctrl.rIn  = 1'b1;
					instrDone = 1'b1;
				end else begin
					ctrl.marIn = 1'b1;
				end
			end
			S_T6: begin
				ctrl.memRead = 1'b1;
				ctrl.mdrIn   = 1'b1;
			end
			S_T7: begin
				ctrl.busSel = BUS_MDR;
				ctrl.gRa    = 1'b1;
				ctrl.rIn    = 1'b1;
				instrDone   = 1'b1;
			end
			default: begin
			end
		endcase
	end

	assign halted = (step == S_HALT);

endmodule

`default_nettype wire

// ==== datapath/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module registerFile
	import isaPkg::*;
(
	input  logic                   clk,
	input  logic                   arstN,
	input  instrT                  ir,
	input  logic                   gRa,
	input  logic                   gRb,
	input  logic                   baOut,
	input  logic                   rIn,
	input  logic [`DATA_WIDTH-1:0] busIn,
	output logic [`DATA_WIDTH-1:0] regOut,
	input  regIdxT                 dbgRegSel,
	output logic [`DATA_WIDTH-1:0] dbgRegData
);

	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
	regIdxT                 sel;

	// Select and encode from the IR fields
	assign sel = gRa ? ir.ra : (gRb ? ir.rb : '0);

	// Base address form, R0 means no base
	assign regOut = (baOut && sel == '0) ? '0 : regs[sel];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (rIn) begin
			regs[sel] <= busIn;
		end
	end

	assign dbgRegData = regs[dbgRegSel];

endmodule

`default_nettype wire

// ==== datapath/datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module datapath
	import ctrlPkg::*, isaPkg::*;
(
	input  logic                   clk,
	input  logic                   arstN,
	ctrlIf.datapath                ctrl,
	output logic [`ADDR_WIDTH-1:0] memAddr,
	input  logic [`DATA_WIDTH-1:0] memRdData,
	input  regIdxT                 dbgRegSel,
	output logic [`DATA_WIDTH-1:0] dbgRegData
);

	localparam logic [`DATA_WIDTH-1:0] PC_STEP = 1;

	logic [`DATA_WIDTH-1:0] bus;
	logic [`DATA_WIDTH-1:0] pc;
	instrT                  ir;
	logic [`DATA_WIDTH-1:0] y;
	logic [`DATA_WIDTH-1:0] z;
	logic [`DATA_WIDTH-1:0] mar;
	logic [`DATA_WIDTH-1:0] mdr;
	logic [`DATA_WIDTH-1:0] regOut;
	logic [`DATA_WIDTH-1:0] constExt;
	instrT                  busInstr;

	registerFile regs (
		.clk        (clk),
		.arstN      (arstN),
		.ir         (ir),
		.gRa        (ctrl.gRa),
		.gRb        (ctrl.gRb),
		.baOut      (ctrl.baOut),
		.rIn        (ctrl.rIn),
		.busIn      (bus),
		.regOut     (regOut),
		.dbgRegSel  (dbgRegSel),
		.dbgRegData (dbgRegData)
	);

	// Sign-extend C to the full word
	assign constExt = {{(`DATA_WIDTH - $bits(constT)){ir.c[$bits(constT)-1]}}, ir.c};

	always_comb begin
		case (ctrl.busSel)
			BUS_PC:    bus = pc;
			BUS_MDR:   bus = mdr;
			BUS_ZLO:   bus = z;
			BUS_REG:   bus = regOut;
			BUS_CONST: bus = constExt;
			default:   bus = '0;
		endcase
	end

	// Look through the IR load so the sequencer can branch at the end of T2
	assign busInstr    = instrT'(bus);
	assign ctrl.opcode = ctrl.irIn ? busInstr.opcode : ir.opcode;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
			ir <= '0;
		end else begin
			if (ctrl.pcInc) begin
				pc <= pc + PC_STEP;
			end
			if (ctrl.irIn) begin
				ir <= busInstr;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.yIn) begin
			y <= bus;
		end
		// Adder is the only ALU operation needed
		if (ctrl.zIn) begin
			z <= y + bus;
		end
		if (ctrl.marIn) begin
			mar <= bus;
		end
		if (ctrl.mdrIn) begin
			mdr <= ctrl.memRead ? memRdData : bus;
		end
	end

	// Memory sees only the low address bits of MAR
	assign memAddr = mar[`ADDR_WIDTH-1:0];

endmodule

`default_nettype wire

// ==== src/mainMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module mainMemory (
	input  logic                   clk,
	input  logic [`ADDR_WIDTH-1:0] addr,
	output logic [`DATA_WIDTH-1:0] rdData,
	input  logic                   wrEn,
	input  logic [`ADDR_WIDTH-1:0] wrAddr,
	input  logic [`DATA_WIDTH-1:0] wrData
);

	logic [`DATA_WIDTH-1:0] mem [`MEM_DEPTH];

	// Read answers in the same cycle
	assign rdData = mem[addr];

	// Preload port, used while the CPU is idle or halted
	always_ff @(posedge clk) begin
		if (wrEn) begin
			mem[wrAddr] <= wrData;
		end
	end

endmodule

`default_nettype wire

// ==== src/loadCpu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module loadCpu
	import isaPkg::*;
(
	input  logic                   clk,
	input  logic                   arstN,
	input  logic                   run,
	input  logic                   memWrEn,
	input  logic [`ADDR_WIDTH-1:0] memWrAddr,
	input  logic [`DATA_WIDTH-1:0] memWrData,
	input  regIdxT                 dbgRegSel,
	output logic [`DATA_WIDTH-1:0] dbgRegData,
	output logic                   instrDone,
	output logic                   halted
);

	logic [`ADDR_WIDTH-1:0] memAddr;
	logic [`DATA_WIDTH-1:0] memRdData;

	ctrlIf ctrlBus ();

	controlSequencer sequencer (
		.clk       (clk),
		.arstN     (arstN),
		.run       (run),
		.ctrl      (ctrlBus.sequencer),
		.instrDone (instrDone),
		.halted    (halted)
	);

	datapath dp (
		.clk        (clk),
		.arstN      (arstN),
		.ctrl       (ctrlBus.datapath),
		.memAddr    (memAddr),
		.memRdData  (memRdData),
		.dbgRegSel  (dbgRegSel),
		.dbgRegData (dbgRegData)
	);

	mainMemory memory (
		.clk    (clk),
		.addr   (memAddr),
		.rdData (memRdData),
		.wrEn   (memWrEn),
		.wrAddr (memWrAddr),
		.wrData (memWrData)
	);

endmodule

`default_nettype wire

// ==== verification/loadCpu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module loadCpu_checker
	import ctrlPkg::*;
(
	input logic clk,
	input logic arstN,
	input stepT step,
	input logic rIn,
	input logic marIn,
	input logic mdrIn,
	input logic instrDone,
	input logic halted
);

	// Register writes only in the last step of ldi or ld
	rInStep: assert property (@(posedge clk) disable iff (!arstN)
		rIn |-> (step == S_T5 || step == S_T7))
		else $error("rIn asserted outside T5 and T7");

	doneWithWrite: assert property (@(posedge clk) disable iff (!arstN)
		instrDone == rIn)
		else $error("instrDone and rIn disagree");

	marMdrExclusive: assert property (@(posedge clk) disable iff (!arstN)
		!(marIn && mdrIn))
		else $error("marIn and mdrIn in the same step");

	// Halt is sticky until reset
	haltedHeld: assert property (@(posedge clk) disable iff (!arstN)
		halted |=> halted)
		else $error("halted dropped without reset");

endmodule

bind controlSequencer loadCpu_checker seqChecks (
	.clk       (clk),
	.arstN     (arstN),
	.step      (step),
	.rIn       (ctrl.rIn),
	.marIn     (ctrl.marIn),
	.mdrIn     (ctrl.mdrIn),
	.instrDone (instrDone),
	.halted    (halted)
);

`default_nettype wire

// ==== verification/loadCpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module loadCpu_tb
	import isaPkg::*;
();

	localparam int PROG_LEN = 10;
	localparam int CYCLE_LIMIT = 8 * PROG_LEN + 100;
	localparam int DATA_BASE = 256;

	// One instruction per row, gap is the expected instrDone spacing
	typedef struct packed {
		opcodeT      op;
		regIdxT      ra;
		regIdxT      rb;
		logic [18:0] c;
		logic [3:0]  gap;
	} entryT;

	logic                   clk = 1'b0;
	logic                   arstN;
	logic                   run;
	logic                   memWrEn;
	logic [`ADDR_WIDTH-1:0] memWrAddr;
	logic [`DATA_WIDTH-1:0] memWrData;
	regIdxT                 dbgRegSel;
	logic [`DATA_WIDTH-1:0] dbgRegData;
	logic                   instrDone;
	logic                   halted;

	entryT                  prog [PROG_LEN];
	logic [`DATA_WIDTH-1:0] memModel [`MEM_DEPTH];
	logic [`DATA_WIDTH-1:0] regModel [`REG_COUNT];
	int                     cycleCount = 0;

	loadCpu DUT (
		.clk        (clk),
		.arstN      (arstN),
		.run        (run),
		.memWrEn    (memWrEn),
		.memWrAddr  (memWrAddr),
		.memWrData  (memWrData),
		.dbgRegSel  (dbgRegSel),
		.dbgRegData (dbgRegData),
		.instrDone  (instrDone),
		.halted     (halted)
	);

	always #2 clk = ~clk;

	// Bound on run length, counted while the CPU runs
	always @(posedge clk) begin
		if (run) begin
			cycleCount <= cycleCount + 1;
			if (cycleCount >= CYCLE_LIMIT) begin
				$display("Timeout: CPU still busy after %0d cycles", CYCLE_LIMIT);
				$display("SIMULATION FAILED");
				$fatal(1, "Timeout");
			end
		end
	end

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
			input string msg);
		if (actual !== expected) begin
			$display("ERROR at %0t ns: %s (got 0x%08h, expected 0x%08h)",
				$time, msg, actual, expected);
			$display("SIMULATION FAILED");
			$fatal(1, "Mismatch");
		end
	endtask

	task automatic writeWord(input int addr, input logic [`DATA_WIDTH-1:0] data);
		@(posedge clk);
		memWrEn   <= 1'b1;
		memWrAddr <= addr[`ADDR_WIDTH-1:0];
		memWrData <= data;
	endtask

	task automatic checkAllRegs(input string when);
		for (int r = 0; r < `REG_COUNT; r++) begin
			@(posedge clk);
			dbgRegSel <= regIdxT'(r);
			@(negedge clk);
			checkValue(dbgRegData, regModel[r], $sformatf("R%0d %s", r, when));
		end
	endtask

	// C is sign-extended, rb of R0 means no base
	function automatic void applyModel(input entryT e);
		logic [31:0] base;
		logic [31:0] addr;
		base = (e.rb == '0) ? '0 : regModel[e.rb];
		addr = base + {{13{e.c[18]}}, e.c};
		if (e.op == OP_LD) begin
			regModel[e.ra] = memModel[addr[`ADDR_WIDTH-1:0]];
		end else begin
			regModel[e.ra] = addr;
		end
	endfunction

	task automatic loadProgram();
		prog[0] = '{OP_LD,   4'd1, 4'd0, 19'd300,   4'd8};
		prog[1] = '{OP_LDI,  4'd2, 4'd0, 19'd400,   4'd6};
		// Negative displacement off R2
		prog[2] = '{OP_LD,   4'd3, 4'd2, -19'sd20,  4'd8};
		prog[3] = '{OP_LDI,  4'd4, 4'd2, 19'd10,    4'd6};
		prog[4] = '{OP_LD,   4'd5, 4'd4, 19'd5,     4'd8};
		prog[5] = '{OP_LDI,  4'd6, 4'd4, -19'sd100, 4'd6};
		prog[6] = '{OP_LD,   4'd7, 4'd6, 19'd0,     4'd8};
		// R0 gets data but still means no base afterwards
		prog[7] = '{OP_LD,   4'd0, 4'd0, 19'd260,   4'd8};
		prog[8] = '{OP_LDI,  4'd8, 4'd0, 19'd7,     4'd6};
		prog[9] = '{OP_HALT, 4'd0, 4'd0, 19'd0,     4'd0};
	endtask

	initial begin
		int                     lastDone;
		logic [`DATA_WIDTH-1:0] lcgState;
		arstN     = 1'b0;
		run       = 1'b0;
		memWrEn   = 1'b0;
		memWrAddr = '0;
		memWrData = '0;
		dbgRegSel = '0;
		lastDone  = 0;
		lcgState  = 32'd13254;
		loadProgram();
		for (int r = 0; r < `REG_COUNT; r++) begin
			regModel[r] = '0;
		end
		repeat (5) @(posedge clk);
		arstN <= 1'b1;

		@(negedge clk);
		checkValue(32'(halted), 0, "halted after reset");
		checkValue(32'(instrDone), 0, "instrDone after reset");
		checkAllRegs("after reset");

		// Program from address 0, random data in the upper half
		for (int i = 0; i < PROG_LEN; i++) begin
			memModel[i] = {prog[i].op, prog[i].ra, prog[i].rb, prog[i].c};
			writeWord(i, memModel[i]);
		end
		for (int a = DATA_BASE; a < `MEM_DEPTH; a++) begin
			lcgState = lcgNext(lcgState);
			memModel[a] = lcgState;
			writeWord(a, lcgState);
		end
		@(posedge clk);
		memWrEn <= 1'b0;
		run     <= 1'b1;

		for (int i = 0; i < PROG_LEN; i++) begin
			if (prog[i].op == OP_HALT) begin
				while (!halted) begin
					@(negedge clk);
				end
			end else begin
				@(negedge clk);
				while (!instrDone) begin
					@(negedge clk);
				end
				applyModel(prog[i]);
				if (i > 0) begin
					checkValue(cycleCount - lastDone, 32'(prog[i].gap),
						$sformatf("instrDone spacing at entry %0d", i));
				end
				lastDone = cycleCount;
				// Written register shows up one cycle after instrDone
				@(posedge clk);
				dbgRegSel <= prog[i].ra;
				@(negedge clk);
				checkValue(dbgRegData, regModel[prog[i].ra],
					$sformatf("R%0d after entry %0d", prog[i].ra, i));
			end
		end

		repeat (20) begin
			@(negedge clk);
			checkValue(32'(instrDone), 0, "instrDone after halt");
		end
		checkValue(32'(halted), 1, "halted held");
		checkAllRegs("after halt");
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+common
common/isaPkg.sv
common/ctrlPkg.sv
common/ctrlIf.sv
src/controlSequencer.sv
datapath/registerFile.sv
datapath/datapath.sv
src/mainMemory.sv
src/loadCpu.sv
verification/loadCpu_checker.sv
verification/loadCpu_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -f flist.f \
	--top-module loadCpu_tb -o loadCpuSim

simStatus=0
./obj_dir/loadCpuSim > sim.log 2>&1 || simStatus=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log || [ "$simStatus" -ne 0 ]; then
	echo "Run failed, see sim.log"
	exit 1
fi
echo "Run finished without failures"
